// File: tb.f
hw/usiBusPkg.sv
hw/microControllerCsr.sv
hw/usiRegBankSlave.sv
hw/microControllerBlock.sv
tests/microControllerBlock_props.sv
tests/microControllerBlockTb.sv

// File: tests/microControllerBlockTb.sv
// Testbench for the USI bus master block: clock, reset, LFSR, host tasks, shadow banks, report
`timescale 1ns/1ps

module microControllerBlockTb;

	// Status polls before a wait gives up
	localparam int cPollLimit = 64;

	logic                sysClk;
	logic                rst;
	logic [2:0]          hostAdrs;
	usiBusPkg::usiWord_t hostWd;
	logic                hostWe;
	logic                hostRe;
	usiBusPkg::usiWord_t hostRd;

	// Expected bank contents per slave
	// Index 0 is block 8'h01 and index 1 is block 8'h02
	usiBusPkg::usiWord_t shadow [2][16];
	logic [31:0]         lfsrState;
	int                  errCount;
	int                  checkCount;
	int                  testCount;
	int                  testErrStart;
	int                  assertFails;
	usiBusPkg::usiAdrs_t adrs;
	usiBusPkg::usiWord_t data;
	usiBusPkg::usiWord_t dataB;
	usiBusPkg::regIdx_t  idx;

	microControllerBlock u_microControllerBlock (
		.sysClk   (sysClk),
		.rst      (rst),
		.hostAdrs (hostAdrs),
		.hostWd   (hostWd),
		.hostWe   (hostWe),
		.hostRe   (hostRe),
		.hostRd   (hostRd)
	);

	always #20 sysClk = ~sysClk;

	// ----------------------------------------------------------------------
	// Stimulus helpers
	// ----------------------------------------------------------------------
	// Taps 32 22 2 1 with one step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsrState = {lfsrState[30:0],
				lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	// Address in slave s with random filler in bits 7:4
	function automatic usiBusPkg::usiAdrs_t mapAdrs(input int s, input usiBusPkg::regIdx_t i);
		logic [3:0] filler;
		filler = 4'(randBits(4));
		return {8'(s + 1), filler, i};
	endfunction

	function automatic int slaveOf(input usiBusPkg::usiAdrs_t a);
		return int'(a[15:8]) - 1;
	endfunction

	// Inputs change 2 ns after the rising edge
	task automatic tick();
		@(posedge sysClk);
		#2;
	endtask

	task automatic writeCsr(input logic [2:0] a, input usiBusPkg::usiWord_t v);
		hostAdrs = a;
		hostWd = v;
		hostWe = 1'b1;
		tick();
		hostWe = 1'b0;
	endtask

	// hostRd is registered, so it is valid after one edge
	task automatic readCsr(input logic [2:0] a, output usiBusPkg::usiWord_t v);
		hostAdrs = a;
		hostRe = 1'b1;
		tick();
		hostRe = 1'b0;
		v = hostRd;
	endtask

	task automatic checkCsr(input logic [2:0] a, input usiBusPkg::usiWord_t want,
			input usiBusPkg::usiWord_t mask, input string name);
		usiBusPkg::usiWord_t got;
		readCsr(a, got);
		checkCount++;
		assert ((got & mask) == (want & mask)) else begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got & mask, want & mask);
			errCount++;
		end
	endtask

	// Poll status until the masked bits match
	task automatic waitStatus(input usiBusPkg::usiWord_t mask, input usiBusPkg::usiWord_t want,
			input string what);
		usiBusPkg::usiWord_t s;
		int polls;
		polls = 0;
		do begin
			readCsr(usiBusPkg::cCsrStatus, s);
			polls++;
		end while (((s & mask) != want) && (polls < cPollLimit));
		if ((s & mask) != want) begin
			$display("Timeout: status never settled for %s after %0d polls", what, polls);
			$display("Testbench failed");
			$finish;
		end
	endtask

	task automatic busWrite(input usiBusPkg::usiAdrs_t a, input usiBusPkg::usiWord_t d);
		writeCsr(usiBusPkg::cCsrBusAdrs, 32'(a));
		writeCsr(usiBusPkg::cCsrBusData, d);
		writeCsr(usiBusPkg::cCsrCommand, 32'h0);
		shadow[slaveOf(a)][a[3:0]] = d;
		waitStatus(32'h1, 32'h0, "bus write");
	endtask

	// Read data arrives with pending low and readValid high together
	task automatic busCheckRead(input usiBusPkg::usiAdrs_t a);
		writeCsr(usiBusPkg::cCsrBusAdrs, 32'(a));
		writeCsr(usiBusPkg::cCsrCommand, 32'h1);
		waitStatus(32'h3, 32'h2, "bus read");
		checkCsr(usiBusPkg::cCsrReadData, shadow[slaveOf(a)][a[3:0]], '1, "readData");
	endtask

	task automatic endTest(input string name);
		assertFails =
			u_microControllerBlock.u_microControllerCsr.u_microControllerBlockProps.failCount;
		$display("Test %0d %s done, %0d value errors, %0d assertion failures so far",
			testCount, name, errCount - testErrStart, assertFails);
		testErrStart = errCount;
		testCount++;
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------
	initial begin
		sysClk = 1'b0;
		rst = 1'b1;
		hostAdrs = '0;
		hostWd = '0;
		hostWe = 1'b0;
		hostRe = 1'b0;
		lfsrState = 32'h7d433ec6;
		errCount = 0;
		checkCount = 0;
		testCount = 0;
		testErrStart = 0;
		for (int s = 0; s < 2; s++) begin
			for (int r = 0; r < 16; r++) begin
				shadow[s][r] = '0;
			end
		end
		repeat (4) @(posedge sysClk);
		#2;
		rst = 1'b0;

		// Only slave 0 credits show after reset
		checkCsr(usiBusPkg::cCsrStatus, 32'h0000_0200, '1, "status");
		for (int s = 0; s < 2; s++) begin
			busCheckRead(mapAdrs(s, usiBusPkg::regIdx_t'(randBits(4))));
		end
		endTest("reset values");

		// Random write then read back on alternating slaves
		for (int n = 0; n < 4; n++) begin
			adrs = mapAdrs(n % 2, usiBusPkg::regIdx_t'(randBits(4)));
			busWrite(adrs, randBits(32));
			busCheckRead(adrs);
		end
		endTest("write and read back");

		// Three commands to slave 0 one CSR write apart drain the credits
		idx = usiBusPkg::regIdx_t'(randBits(4));
		data = randBits(32);
		adrs = mapAdrs(0, idx);
		writeCsr(usiBusPkg::cCsrBusAdrs, 32'(adrs));
		writeCsr(usiBusPkg::cCsrBusData, data);
		for (int n = 0; n < 3; n++) begin
			if (n > 0) begin
				adrs = mapAdrs(0, idx + usiBusPkg::regIdx_t'(n));
				writeCsr(usiBusPkg::cCsrBusAdrs, 32'(adrs));
			end
			writeCsr(usiBusPkg::cCsrCommand, 32'h0);
			shadow[0][adrs[3:0]] = data;
		end
		// Third one parked in waitCredit
		checkCsr(usiBusPkg::cCsrStatus, 32'h0000_0001, 32'h0000_0301, "status");
		waitStatus(32'h0000_0301, 32'h0000_0200, "credit recovery");
		for (int n = 0; n < 3; n++) begin
			busCheckRead(mapAdrs(0, idx + usiBusPkg::regIdx_t'(n)));
		end
		endTest("credit stall");

		// Read behind two writes to one register sees the later write
		idx = usiBusPkg::regIdx_t'(randBits(4));
		adrs = mapAdrs(1, idx);
		data = randBits(32);
		dataB = randBits(32);
		writeCsr(usiBusPkg::cCsrBusAdrs, 32'(adrs));
		writeCsr(usiBusPkg::cCsrBusData, data);
		writeCsr(usiBusPkg::cCsrCommand, 32'h0);
		writeCsr(usiBusPkg::cCsrBusData, dataB);
		writeCsr(usiBusPkg::cCsrCommand, 32'h0);
		shadow[1][idx] = dataB;
		// Rewriting the address gives pending a cycle to fall
		writeCsr(usiBusPkg::cCsrBusAdrs, 32'(adrs));
		writeCsr(usiBusPkg::cCsrCommand, 32'h1);
		waitStatus(32'h1, 32'h0, "queued read");
		checkCsr(usiBusPkg::cCsrReadData, dataB, '1, "readData");
		endTest("in-order retire");

		// Block 8'h05 has no slave
		idx = usiBusPkg::regIdx_t'(randBits(4));
		writeCsr(usiBusPkg::cCsrBusAdrs, {16'h0, 8'h05, 4'(randBits(4)), idx});
		writeCsr(usiBusPkg::cCsrBusData, randBits(32));
		writeCsr(usiBusPkg::cCsrCommand, 32'h0);
		checkCsr(usiBusPkg::cCsrStatus, 32'h0000_0004, 32'h0000_000f, "status");
		checkCsr(usiBusPkg::cCsrStatus, 32'h0, 32'h0000_0004, "status");
		busCheckRead(mapAdrs(0, idx));
		busCheckRead(mapAdrs(1, idx));
		endTest("unmapped block");

		// Write command while a read is outstanding
		idx = usiBusPkg::regIdx_t'(randBits(4));
		adrs = mapAdrs(1, idx);
		writeCsr(usiBusPkg::cCsrBusAdrs, 32'(adrs));
		writeCsr(usiBusPkg::cCsrCommand, 32'h1);
		writeCsr(usiBusPkg::cCsrBusData, randBits(32));
		writeCsr(usiBusPkg::cCsrCommand, 32'h0);
		checkCsr(usiBusPkg::cCsrStatus, 32'h0000_0009, 32'h0000_0009, "status");
		waitStatus(32'h1, 32'h0, "read with dropped command");
		checkCsr(usiBusPkg::cCsrReadData, shadow[1][idx], '1, "readData");
		busCheckRead(adrs);
		endTest("dropped command");

		assertFails =
			u_microControllerBlock.u_microControllerCsr.u_microControllerBlockProps.failCount;
		$display("Tests %0d, value checks %0d, value errors %0d, assertion failures %0d",
			testCount, checkCount, errCount, assertFails);
		if ((errCount == 0) && (assertFails == 0)) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: tests/microControllerBlock_props.sv
// Bound assertions on bus master select, strobes, credit limits and read return ordering
`timescale 1ns/1ps

module microControllerBlockProps #(
	parameter pBusBlockConnect = 2
)(
	input logic                        sysClk,
	input logic                        rst,
	input logic                        usiWEd,
	input logic                        usiREq,
	input logic [pBusBlockConnect-1:0] usiSel,
	input logic [pBusBlockConnect-1:0] usiREd,
	input logic                        pending,
	input usiBusPkg::credit_t          credit [pBusBlockConnect]
);

	// Count of failed assertions
	int failCount = 0;

	// ----------------------------------------------------------------------
	// Select and strobes
	// ----------------------------------------------------------------------
	// At most one target and only while a strobe is out
	selOneHot: assert property (@(posedge sysClk) disable iff (rst)
		$onehot0(usiSel) && ((usiWEd || usiREq) == (usiSel != '0)))
		else begin
			failCount++;
			$error("usiSel %b not one-hot or out of step with the strobes", usiSel);
		end

	// Read data only answers an outstanding read
	readOnlyWhenPending: assert property (@(posedge sysClk) disable iff (rst)
		(usiREd != '0) |-> pending)
		else begin
			failCount++;
			$error("usiREd %b with no read pending", usiREd);
		end

	// ----------------------------------------------------------------------
	// Per-slave credits
	// ----------------------------------------------------------------------
	for (genvar i = 0; i < pBusBlockConnect; i++) begin : gCredit
		// A strobe spends a credit, so one must be there
		strobeHasCredit: assert property (@(posedge sysClk) disable iff (rst)
			usiSel[i] |-> (credit[i] != '0))
			else begin
				failCount++;
				$error("Strobe to slave %0d with zero credits", i);
			end

		// Returned credits stop at the queue depth
		creditBounded: assert property (@(posedge sysClk) disable iff (rst)
			credit[i] <= usiBusPkg::cCreditDepth)
			else begin
				failCount++;
				$error("Slave %0d credit %0d above depth", i, credit[i]);
			end
	end

endmodule

bind microControllerCsr microControllerBlockProps #(
	.pBusBlockConnect (pBusBlockConnect)
) u_microControllerBlockProps (
	.sysClk  (sysClk),
	.rst     (rst),
	.usiWEd  (usiWEd),
	.usiREq  (usiREq),
	.usiSel  (usiSel),
	.usiREd  (usiREd),
	.pending (pending),
	.credit  (credit)
);

// File: hw/microControllerBlock.sv
// Top level with the USI bus master controller and its register bank slaves
`timescale 1ns/1ps

module microControllerBlock #(
	parameter pBusBlockConnect = 2,
	parameter pBlockAdrsMap = 8,
	parameter [pBusBlockConnect*pBlockAdrsMap-1:0] pAdrsMap = {8'h02, 8'h01},
	parameter pDrainDelay = 3
)(
	input  logic                sysClk,
	input  logic                rst,
	// Host port
	input  logic [2:0]          hostAdrs,
	input  usiBusPkg::usiWord_t hostWd,
	input  logic                hostWe,
	input  logic                hostRe,
	output usiBusPkg::usiWord_t hostRd
);

	// Master to slaves
	usiBusPkg::usiWord_t         usiWd;
	usiBusPkg::usiAdrs_t         usiAdrs;
	logic                        usiWEd;
	logic                        usiREq;
	logic [pBusBlockConnect-1:0] usiSel;
	// Slaves to master
	usiBusPkg::usiWord_t         slaveRd [pBusBlockConnect];
	usiBusPkg::usiWord_t         usiRd;
	logic [pBusBlockConnect-1:0] usiREd;
	logic [pBusBlockConnect-1:0] usiCredit;

	// Idle slaves drive zero, so OR merges the read data
	always_comb begin
		usiRd = '0;
		for (int i = 0; i < pBusBlockConnect; i++) usiRd = usiRd | slaveRd[i];
	end

	// ----------------------------------------------------------------------
	// Bus master
	// ----------------------------------------------------------------------
	microControllerCsr #(
		.pBusBlockConnect (pBusBlockConnect),
		.pBlockAdrsMap    (pBlockAdrsMap),
		.pAdrsMap         (pAdrsMap)
	) u_microControllerCsr (
		.sysClk    (sysClk),
		.rst       (rst),
		.hostAdrs  (hostAdrs),
		.hostWd    (hostWd),
		.hostWe    (hostWe),
		.hostRe    (hostRe),
		.hostRd    (hostRd),
		.usiRd     (usiRd),
		.usiREd    (usiREd),
		.usiCredit (usiCredit),
		.usiWd     (usiWd),
		.usiAdrs   (usiAdrs),
		.usiWEd    (usiWEd),
		.usiREq    (usiREq),
		.usiSel    (usiSel)
	);

	// ----------------------------------------------------------------------
	// Register bank slaves, slave i answers map field i
	// ----------------------------------------------------------------------
	for (genvar i = 0; i < pBusBlockConnect; i++) begin : gSlave
		usiRegBankSlave #(
			.pDrainDelay (pDrainDelay)
		) u_usiRegBankSlave (
			.sysClk    (sysClk),
			.rst       (rst),
			.usiSel    (usiSel[i]),
			.usiWd     (usiWd),
			.usiAdrs   (usiAdrs),
			.usiWEd    (usiWEd),
			.usiREq    (usiREq),
			.usiRd     (slaveRd[i]),
			.usiREd    (usiREd[i]),
			.usiCredit (usiCredit[i])
		);
	end

endmodule

// File: hw/usiRegBankSlave.sv
// USI register bank slave with two-entry request FIFO, paced drain and credit return
`timescale 1ns/1ps

module usiRegBankSlave #(
	parameter pDrainDelay = 3
)(
	input  logic                sysClk,
	input  logic                rst,
	// Bus request side
	input  logic                usiSel,
	input  usiBusPkg::usiWord_t usiWd,
	input  usiBusPkg::usiAdrs_t usiAdrs,
	input  logic                usiWEd,
	input  logic                usiREq,
	// Return side
	output usiBusPkg::usiWord_t usiRd,
	output logic                usiREd,
	output logic                usiCredit
);

	// Queue depth matches the credits the master hands out
	localparam int cDepth = usiBusPkg::cCreditDepth;
	localparam int cPtrWidth = $clog2(cDepth);
	localparam int cCntWidth = $clog2(pDrainDelay + 1);
	localparam int cBankSize = 2 ** $bits(usiBusPkg::regIdx_t);

	// Request FIFO storage
	logic                  qRead [cDepth];
	usiBusPkg::regIdx_t    qIdx [cDepth];
	usiBusPkg::usiWord_t   qData [cDepth];
	logic [cPtrWidth-1:0]  wrPtr;
	logic [cPtrWidth-1:0]  rdPtr;
	usiBusPkg::credit_t    qCount;
	// Drain pacing
	logic [cCntWidth-1:0]  drainCnt;
	logic                  push;
	logic                  retire;
	// Register bank
	usiBusPkg::usiWord_t   bank [cBankSize];

	// ----------------------------------------------------------------------
	// Request FIFO
	// ----------------------------------------------------------------------
	assign push = usiSel && (usiWEd || usiREq);

	// Head entry leaves after pDrainDelay cycles at the head
	assign retire = (qCount != '0) && (drainCnt == cCntWidth'(pDrainDelay - 1));

	always_ff @(posedge sysClk) begin
		if (push) begin
			qRead[wrPtr] <= usiREq;
			qIdx[wrPtr] <= usiAdrs[$bits(usiBusPkg::regIdx_t)-1:0];
			qData[wrPtr] <= usiWd;
		end
	end

	always_ff @(posedge sysClk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			qCount <= '0;
		end else begin
			if (push) wrPtr <= wrPtr + 1'b1;
			if (retire) rdPtr <= rdPtr + 1'b1;
			case ({push, retire})
				2'b10:   qCount <= qCount + usiBusPkg::credit_t'(1);
				2'b01:   qCount <= qCount - usiBusPkg::credit_t'(1);
				default: qCount <= qCount;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// Drain pacing
	// ----------------------------------------------------------------------
	// Restart whenever a new entry becomes the head
	always_ff @(posedge sysClk) begin
		if (rst) begin
			drainCnt <= '0;
		end else if ((qCount == '0) || retire) begin
			drainCnt <= '0;
		end else begin
			drainCnt <= drainCnt + 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// Register bank and return path
	// ----------------------------------------------------------------------
	always_ff @(posedge sysClk) begin
		if (rst) begin
			for (int i = 0; i < cBankSize; i++) bank[i] <= '0;
			usiRd <= '0;
			usiREd <= 1'b0;
			usiCredit <= 1'b0;
		end else begin
			// One credit per retired entry, read or write
			usiCredit <= retire;
			usiREd <= retire && qRead[rdPtr];
			// Data stays zero outside a read return so the top can OR it
			usiRd <= '0;
			if (retire) begin
				if (qRead[rdPtr]) begin
					usiRd <= bank[qIdx[rdPtr]];
				end else begin
					bank[qIdx[rdPtr]] <= qData[rdPtr];
				end
			end
		end
	end

endmodule

// File: hw/microControllerCsr.sv
// Host CSR file, block decode to slave select, per-slave credits, bus master FSM, read capture
`timescale 1ns/1ps

module microControllerCsr #(
	parameter pBusBlockConnect = 2,
	parameter pBlockAdrsMap = 8,
	parameter [pBusBlockConnect*pBlockAdrsMap-1:0] pAdrsMap = {8'h02, 8'h01}
)(
	input  logic                        sysClk,
	input  logic                        rst,
	// Host port
	input  logic [2:0]                  hostAdrs,
	input  usiBusPkg::usiWord_t         hostWd,
	input  logic                        hostWe,
	input  logic                        hostRe,
	output usiBusPkg::usiWord_t         hostRd,
	// Slave return side
	input  usiBusPkg::usiWord_t         usiRd,
	input  logic [pBusBlockConnect-1:0] usiREd,
	input  logic [pBusBlockConnect-1:0] usiCredit,
	// Bus master outputs
	output usiBusPkg::usiWord_t         usiWd,
	output usiBusPkg::usiAdrs_t         usiAdrs,
	output logic                        usiWEd,
	output logic                        usiREq,
	output logic [pBusBlockConnect-1:0] usiSel
);

	// Host registers
	usiBusPkg::usiAdrs_t         busAdrs;
	usiBusPkg::usiWord_t         busData;
	usiBusPkg::usiWord_t         readData;
	// Accepted transaction
	usiBusPkg::usiAdrs_t         txAdrs;
	usiBusPkg::usiWord_t         txData;
	logic [pBusBlockConnect-1:0] txSel;
	logic                        txRead;
	// Status flags
	logic                        pending;
	logic                        readValid;
	logic                        unmapped;
	logic                        cmdDropped;
	usiBusPkg::usiWord_t         statusWord;
	// Sequencer and credits
	usiBusPkg::mcState_t         state;
	usiBusPkg::credit_t          credit [pBusBlockConnect];
	logic [pBusBlockConnect-1:0] creditInc;
	logic [pBusBlockConnect-1:0] creditDec;
	// Decode
	logic [pBlockAdrsMap-1:0]    blockId;
	logic [pBusBlockConnect-1:0] blockHit;
	logic                        hitCreditOk;
	logic                        txCreditOk;
	logic                        cmdWrite;
	logic                        cmdAccept;

	// ----------------------------------------------------------------------
	// Address decode
	// ----------------------------------------------------------------------
	assign blockId = busAdrs[$bits(usiBusPkg::usiAdrs_t)-1 -: pBlockAdrsMap];

	// One map field per slave, slave 0 in the low field
	always_comb begin
		for (int i = 0; i < pBusBlockConnect; i++) begin
			blockHit[i] = (blockId == pAdrsMap[i*pBlockAdrsMap +: pBlockAdrsMap]);
		end
	end

	// Credit left for the decoded target and for the latched one
	always_comb begin
		hitCreditOk = 1'b0;
		txCreditOk = 1'b0;
		for (int i = 0; i < pBusBlockConnect; i++) begin
			if (blockHit[i] && (credit[i] != '0)) hitCreditOk = 1'b1;
			if (txSel[i] && (credit[i] != '0)) txCreditOk = 1'b1;
		end
	end

	assign cmdWrite = hostWe && (hostAdrs == usiBusPkg::cCsrCommand);
	// Only one transaction outstanding
	assign cmdAccept = cmdWrite && !pending;

	// ----------------------------------------------------------------------
	// Host CSR access
	// ----------------------------------------------------------------------
	always_comb begin
		statusWord = '0;
		statusWord[0] = pending;
		statusWord[1] = readValid;
		statusWord[2] = unmapped;
		statusWord[3] = cmdDropped;
		statusWord[9:8] = credit[0];
	end

	always_ff @(posedge sysClk) begin
		if (rst) begin
			busAdrs <= '0;
			busData <= '0;
			hostRd <= '0;
		end else begin
			if (hostWe && (hostAdrs == usiBusPkg::cCsrBusAdrs))
				busAdrs <= hostWd[$bits(usiBusPkg::usiAdrs_t)-1:0];
			if (hostWe && (hostAdrs == usiBusPkg::cCsrBusData))
				busData <= hostWd;
			if (hostRe) begin
				case (hostAdrs)
					usiBusPkg::cCsrBusAdrs:  hostRd <= usiBusPkg::usiWord_t'(busAdrs);
					usiBusPkg::cCsrBusData:  hostRd <= busData;
					usiBusPkg::cCsrCommand:  hostRd <= usiBusPkg::usiWord_t'(txRead);
					usiBusPkg::cCsrStatus:   hostRd <= statusWord;
					usiBusPkg::cCsrReadData: hostRd <= readData;
					default:                 hostRd <= '0;
				endcase
			end
		end
	end

	// Payload of the accepted command
	always_ff @(posedge sysClk) begin
		if (cmdAccept) begin
			txAdrs <= busAdrs;
			txData <= busData;
		end
	end

	// ----------------------------------------------------------------------
	// Bus master sequencer
	// ----------------------------------------------------------------------
	always_ff @(posedge sysClk) begin
		if (rst) begin
			state <= usiBusPkg::idle;
			txSel <= '0;
			txRead <= 1'b0;
			pending <= 1'b0;
			readValid <= 1'b0;
			unmapped <= 1'b0;
			cmdDropped <= 1'b0;
			readData <= '0;
		end else begin
			// Sticky flags clear on status read, a new event below wins
			if (hostRe && (hostAdrs == usiBusPkg::cCsrStatus)) begin
				readValid <= 1'b0;
				unmapped <= 1'b0;
				cmdDropped <= 1'b0;
			end
			case (state)
				usiBusPkg::idle: begin
					if (cmdAccept) begin
						txSel <= blockHit;
						txRead <= hostWd[0];
						if (blockHit == '0) begin
							// No slave owns this block, nothing goes on the bus
							unmapped <= 1'b1;
						end else begin
							pending <= 1'b1;
							state <= hitCreditOk ? usiBusPkg::issue : usiBusPkg::waitCredit;
						end
					end
				end
				usiBusPkg::waitCredit: begin
					if (txCreditOk) state <= usiBusPkg::issue;
				end
				usiBusPkg::issue: begin
					state <= usiBusPkg::idle;
					// Write done once on the bus, read waits for usiREd
					if (!txRead) pending <= 1'b0;
				end
				default: state <= usiBusPkg::idle;
			endcase
			if (cmdWrite && pending) cmdDropped <= 1'b1;
			if (usiREd != '0) begin
				readData <= usiRd;
				readValid <= 1'b1;
				pending <= 1'b0;
			end
		end
	end

	// Strobes live for the single issue cycle
	assign usiWd = txData;
	assign usiAdrs = txAdrs;
	assign usiWEd = (state == usiBusPkg::issue) && !txRead;
	assign usiREq = (state == usiBusPkg::issue) && txRead;
	assign usiSel = (state == usiBusPkg::issue) ? txSel : '0;

	// ----------------------------------------------------------------------
	// Credit counters
	// ----------------------------------------------------------------------
	always_comb begin
		for (int i = 0; i < pBusBlockConnect; i++) begin
			creditInc[i] = usiCredit[i] && (credit[i] != usiBusPkg::cCreditDepth);
			creditDec[i] = usiSel[i];
		end
	end

	always_ff @(posedge sysClk) begin
		if (rst) begin
			for (int i = 0; i < pBusBlockConnect; i++) credit[i] <= usiBusPkg::cCreditDepth;
		end else begin
			for (int i = 0; i < pBusBlockConnect; i++) begin
				case ({creditInc[i], creditDec[i]})
					2'b10:   credit[i] <= credit[i] + usiBusPkg::credit_t'(1);
					2'b01:   credit[i] <= credit[i] - usiBusPkg::credit_t'(1);
					default: credit[i] <= credit[i];
				endcase
			end
		end
	end

endmodule

// File: hw/usiBusPkg.sv
// USI bus word and address types, host CSR offsets, credit depth, controller FSM states
package usiBusPkg;

	// ----------------------------------------------------------------------
	// Bus payload types
	// ----------------------------------------------------------------------
	// One bus data word
	typedef logic [31:0] usiWord_t;

	// Bus address
	// [15:8] block id, [7:4] unused, [3:0] register index
	typedef logic [15:0] usiAdrs_t;

	// Register index inside one slave bank
	typedef logic [3:0] regIdx_t;

	// Credit count per slave, wide enough for the queue depth
	typedef logic [1:0] credit_t;

	// ----------------------------------------------------------------------
	// Flow control
	// ----------------------------------------------------------------------
	// Slave queue depth, also the credit each slave starts with
	localparam credit_t cCreditDepth = 2'd2;

	// ----------------------------------------------------------------------
	// Host CSR offsets
	// ----------------------------------------------------------------------
	// Target bus address
	localparam logic [2:0] cCsrBusAdrs = 3'd0;
	// Write data for the next transaction
	localparam logic [2:0] cCsrBusData = 3'd1;
	// Bit 0 high for read, writing it launches a transaction
	localparam logic [2:0] cCsrCommand = 3'd2;
	// Flags and slave 0 credits, sticky bits clear on read
	localparam logic [2:0] cCsrStatus = 3'd3;
	// Last word returned by a slave
	localparam logic [2:0] cCsrReadData = 3'd4;

	// Bus master sequencer states
	typedef enum logic [1:0] {
		idle       = 2'd0,
		waitCredit = 2'd1,
		issue      = 2'd2
	} mcState_t;

endpackage
